// ==== design/conv_arith_pkg.sv ====
`default_nettype none

package conv_arith_pkg;

	// one input pixel and one kernel weight, both signed
	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;

	// wide enough for K*K*channels products plus the bias
	typedef logic signed [23:0] acc_t;

	// activation after relu, unsigned
	typedef logic [7:0] out_t;

	// clamp to the 8 bit activation range
	function automatic out_t relu_sat(input acc_t value);
		if (value < 0)
		begin
			return '0;
		end
		else if (value > 255)
		begin
			return 8'hff;
		end
		else
		begin
			return out_t'(value[7:0]);
		end
	endfunction

endpackage

`default_nettype wire

// ==== design/conv_ctrl_pkg.sv ====
`default_nettype none

package conv_ctrl_pkg;

	// configuration beat opcodes
	typedef enum logic [1:0] {
		op_nop,
		op_wr_weight,
		op_wr_bias
	} cfg_op_t;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/conv_window_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window_unit #(
	parameter int IFM_SIZE = 5,
	parameter int KERNEL_SIZE = 3,
	parameter int NUM_FILTERS = 4,
	localparam int KK = KERNEL_SIZE * KERNEL_SIZE,
	localparam int WADDR_W = (NUM_FILTERS * KK > 1) ? $clog2(NUM_FILTERS * KK) : 1,
	localparam int FILT_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1
) (
	input logic clk,
	input conv_arith_pkg::pixel_t pixel,
	input logic shift_en,
	input logic advance,
	input logic wr_en,
	input logic [WADDR_W-1:0] wr_addr,
	input conv_arith_pkg::weight_t wr_data,
	input logic [FILT_W-1:0] filter_sel,
	output conv_arith_pkg::acc_t unit_sum
);

	import conv_arith_pkg::*;

	// the incoming pixel plus the stored line makes the full window span
	localparam int LINE_LEN = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	pixel_t line_q [LINE_LEN-1];
	pixel_t win [LINE_LEN];
	weight_t weights [NUM_FILTERS*KK];
	acc_t dot;

	// age in the line of raster tap t, newest pixel is age 0
	function automatic int tap_age(input int t);
		return (KERNEL_SIZE - 1 - t / KERNEL_SIZE) * IFM_SIZE + (KERNEL_SIZE - 1 - t % KERNEL_SIZE);
	endfunction

	always_comb
	begin
		win[0] = pixel;
		for (int k = 1; k < LINE_LEN; k++)
		begin
			win[k] = line_q[k-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			for (int k = 0; k < LINE_LEN - 1; k++)
			begin
				line_q[k] <= win[k];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			weights[wr_addr] <= wr_data;
		end
	end

	// all taps of the selected filter in one cycle
	always_comb
	begin
		dot = '0;
		for (int t = 0; t < KK; t++)
		begin
			dot += acc_t'(win[tap_age(t)]) * acc_t'(weights[int'(filter_sel) * KK + t]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			unit_sum <= dot;
		end
	end

	a_wr_addr_range: assert property (@(posedge clk) wr_en |-> int'(wr_addr) < NUM_FILTERS * KK)
		else $error("weight write address %0d out of range", wr_addr);

endmodule

`default_nettype wire

// ==== design/channel_sum_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_sum_tree #(
	parameter int NUM_UNITS = 3
) (
	input logic clk,
	input logic advance,
	input conv_arith_pkg::acc_t unit_sums [NUM_UNITS],
	output conv_arith_pkg::acc_t tree_sum
);

	import conv_arith_pkg::*;

	localparam int TREE_LEVELS = $clog2(NUM_UNITS);

	if (TREE_LEVELS == 0)
	begin : g_single
		assign tree_sum = unit_sums[0];
	end
	else
	begin : g_tree
		acc_t lvl_in [TREE_LEVELS][NUM_UNITS];
		acc_t lvl_q [TREE_LEVELS][NUM_UNITS];

		for (genvar l = 0; l < TREE_LEVELS; l++)
		begin : g_lvl
			localparam int N_IN = (NUM_UNITS + (1 << l) - 1) >> l;
			localparam int N_OUT = (N_IN + 1) / 2;

			for (genvar i = 0; i < N_IN; i++)
			begin : g_src
				if (l == 0)
				begin : g_first
					assign lvl_in[l][i] = unit_sums[i];
				end
				else
				begin : g_prev
					assign lvl_in[l][i] = lvl_q[l-1][i];
				end
			end

			for (genvar i = 0; i < N_OUT; i++)
			begin : g_node
				if (2 * i + 1 < N_IN)
				begin : g_add
					always_ff @(posedge clk)
					begin
						if (advance)
						begin
							lvl_q[l][i] <= lvl_in[l][2*i] + lvl_in[l][2*i+1];
						end
					end
				end
				else
				begin : g_pass
					// odd one out keeps pace with its neighbours
					always_ff @(posedge clk)
					begin
						if (advance)
						begin
							lvl_q[l][i] <= lvl_in[l][2*i];
						end
					end
				end
			end
		end

		assign tree_sum = lvl_q[TREE_LEVELS-1][0];
	end

endmodule

`default_nettype wire

// ==== design/bias_relu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bias_relu_stage #(
	parameter int NUM_FILTERS = 4,
	localparam int FILT_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1
) (
	input logic clk,
	input logic rst,
	input conv_arith_pkg::acc_t tree_sum,
	input logic sum_valid,
	input logic [FILT_W-1:0] sum_filter,
	input logic bias_wr_en,
	input logic [FILT_W-1:0] bias_addr,
	input conv_arith_pkg::acc_t bias_data,
	input logic out_ready,
	output logic advance,
	output logic out_valid,
	output conv_arith_pkg::out_t out_data
);

	import conv_arith_pkg::*;

	acc_t bias_mem [NUM_FILTERS];
	acc_t biased;

	always_ff @(posedge clk)
	begin
		if (bias_wr_en)
		begin
			bias_mem[bias_addr] <= bias_data;
		end
	end

	assign biased = tree_sum + bias_mem[sum_filter];

	// whole pipeline moves only when the output slot can take a beat
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else if (advance)
		begin
			out_valid <= sum_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			out_data <= relu_sat(biased);
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("output changed while stalled");

endmodule

`default_nettype wire

// ==== design/conv_layer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_ctrl #(
	parameter int IFM_SIZE = 5,
	parameter int KERNEL_SIZE = 3,
	parameter int NUM_FILTERS = 4,
	parameter int NUM_UNITS = 3,
	localparam int KK = KERNEL_SIZE * KERNEL_SIZE,
	localparam int WADDR_W = (NUM_FILTERS * KK > 1) ? $clog2(NUM_FILTERS * KK) : 1,
	localparam int FILT_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1,
	localparam int UNIT_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
	input logic clk,
	input logic rst,
	input logic cfg_valid,
	input conv_ctrl_pkg::cfg_op_t cfg_op,
	input logic [UNIT_W-1:0] cfg_unit,
	input logic [WADDR_W-1:0] cfg_addr,
	input conv_arith_pkg::acc_t cfg_data,
	input logic start,
	input logic in_valid,
	input logic advance,
	input logic out_valid,
	output logic cfg_ready,
	output logic in_ready,
	output logic busy,
	output logic shift_en,
	output logic [NUM_UNITS-1:0] unit_wr_en,
	output logic [WADDR_W-1:0] wr_addr,
	output conv_arith_pkg::weight_t wr_data,
	output logic bias_wr_en,
	output logic [FILT_W-1:0] filter_sel,
	output logic sum_valid,
	output logic [FILT_W-1:0] sum_filter
);

	import conv_arith_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int TREE_LEVELS = $clog2(NUM_UNITS);
	localparam int TAG_LEN = 1 + TREE_LEVELS;
	localparam int POS_W = (IFM_SIZE > 1) ? $clog2(IFM_SIZE) : 1;

	ctrl_state_t state;
	logic [POS_W-1:0] col_cnt;
	logic [POS_W-1:0] row_cnt;
	logic [FILT_W-1:0] filt_cnt;
	logic cfg_fire;
	logic last_pixel;
	logic last_filter;
	logic win_valid;
	logic [TAG_LEN-1:0] tag_v;
	logic [FILT_W-1:0] tag_f [TAG_LEN];

	assign cfg_ready = (state == st_idle);
	assign busy = (state != st_idle);
	assign cfg_fire = cfg_valid && cfg_ready;

	assign unit_wr_en = (cfg_fire && cfg_op == op_wr_weight) ? NUM_UNITS'(1) << cfg_unit : '0;
	assign bias_wr_en = cfg_fire && cfg_op == op_wr_bias;
	assign wr_addr = cfg_addr;
	assign wr_data = weight_t'(cfg_data[7:0]);

	assign in_ready = (state == st_run) && advance;
	assign shift_en = in_valid && in_ready;
	assign filter_sel = filt_cnt;

	assign last_pixel = (col_cnt == POS_W'(IFM_SIZE - 1)) && (row_cnt == POS_W'(IFM_SIZE - 1));
	assign last_filter = (filt_cnt == FILT_W'(NUM_FILTERS - 1));

	// window is complete once K-1 rows and columns are behind this pixel
	assign win_valid = shift_en && row_cnt >= POS_W'(KERNEL_SIZE - 1)
		&& col_cnt >= POS_W'(KERNEL_SIZE - 1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
		end
		else
		begin
			case (state)
				st_idle:
					if (start)
						state <= st_run;
				st_run:
					if (shift_en && last_pixel && last_filter)
						state <= st_drain;
				st_drain:
					if (tag_v == '0 && !out_valid)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// raster position and filter of the next pixel to arrive
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			col_cnt <= '0;
			row_cnt <= '0;
			filt_cnt <= '0;
		end
		else if (shift_en)
		begin
			if (col_cnt == POS_W'(IFM_SIZE - 1))
			begin
				col_cnt <= '0;
				if (row_cnt == POS_W'(IFM_SIZE - 1))
				begin
					row_cnt <= '0;
					filt_cnt <= last_filter ? '0 : filt_cnt + 1'b1;
				end
				else
				begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// tag follows the unit register and then each tree level
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tag_v <= '0;
		end
		else if (advance)
		begin
			tag_v[0] <= win_valid;
			for (int i = 1; i < TAG_LEN; i++)
			begin
				tag_v[i] <= tag_v[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			tag_f[0] <= filt_cnt;
			for (int i = 1; i < TAG_LEN; i++)
			begin
				tag_f[i] <= tag_f[i-1];
			end
		end
	end

	assign sum_valid = tag_v[TAG_LEN-1];
	assign sum_filter = tag_f[TAG_LEN-1];

	a_in_ready_run: assert property (@(posedge clk) disable iff (rst) in_ready |-> state == st_run)
		else $error("in_ready high outside run state");

	a_wr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(unit_wr_en))
		else $error("more than one unit weight write enable");

endmodule

`default_nettype wire

// ==== design/conv_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top #(
	parameter int IFM_SIZE = 5,
	parameter int KERNEL_SIZE = 3,
	parameter int NUM_FILTERS = 4,
	parameter int NUM_UNITS = 3,
	localparam int KK = KERNEL_SIZE * KERNEL_SIZE,
	localparam int WADDR_W = (NUM_FILTERS * KK > 1) ? $clog2(NUM_FILTERS * KK) : 1,
	localparam int FILT_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1,
	localparam int UNIT_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1,
	localparam int PIX_W = $bits(conv_arith_pkg::pixel_t)
) (
	input logic clk,
	input logic rst,
	input logic cfg_valid,
	output logic cfg_ready,
	input conv_ctrl_pkg::cfg_op_t cfg_op,
	input logic [UNIT_W-1:0] cfg_unit,
	input logic [WADDR_W-1:0] cfg_addr,
	input conv_arith_pkg::acc_t cfg_data,
	input logic start,
	input logic in_valid,
	output logic in_ready,
	input logic [NUM_UNITS*PIX_W-1:0] in_pixels,
	output logic out_valid,
	input logic out_ready,
	output conv_arith_pkg::out_t out_data,
	output logic busy
);

	import conv_arith_pkg::*;

	logic advance;
	logic shift_en;
	logic [NUM_UNITS-1:0] unit_wr_en;
	logic [WADDR_W-1:0] wr_addr;
	weight_t wr_data;
	logic bias_wr_en;
	logic [FILT_W-1:0] filter_sel;
	logic sum_valid;
	logic [FILT_W-1:0] sum_filter;
	acc_t unit_sum [NUM_UNITS];
	acc_t tree_sum;

	conv_layer_ctrl #(
		.IFM_SIZE(IFM_SIZE),
		.KERNEL_SIZE(KERNEL_SIZE),
		.NUM_FILTERS(NUM_FILTERS),
		.NUM_UNITS(NUM_UNITS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.cfg_valid(cfg_valid),
		.cfg_op(cfg_op),
		.cfg_unit(cfg_unit),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.start(start),
		.in_valid(in_valid),
		.advance(advance),
		.out_valid(out_valid),
		.cfg_ready(cfg_ready),
		.in_ready(in_ready),
		.busy(busy),
		.shift_en(shift_en),
		.unit_wr_en(unit_wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.bias_wr_en(bias_wr_en),
		.filter_sel(filter_sel),
		.sum_valid(sum_valid),
		.sum_filter(sum_filter)
	);

	// one unit per input channel, channel 0 in the low pixel lane
	for (genvar u = 0; u < NUM_UNITS; u++)
	begin : g_unit
		conv_window_unit #(
			.IFM_SIZE(IFM_SIZE),
			.KERNEL_SIZE(KERNEL_SIZE),
			.NUM_FILTERS(NUM_FILTERS)
		) u_unit (
			.clk(clk),
			.pixel(in_pixels[u*PIX_W +: PIX_W]),
			.shift_en(shift_en),
			.advance(advance),
			.wr_en(unit_wr_en[u]),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.filter_sel(filter_sel),
			.unit_sum(unit_sum[u])
		);
	end

	channel_sum_tree #(
		.NUM_UNITS(NUM_UNITS)
	) u_tree (
		.clk(clk),
		.advance(advance),
		.unit_sums(unit_sum),
		.tree_sum(tree_sum)
	);

	bias_relu_stage #(
		.NUM_FILTERS(NUM_FILTERS)
	) u_bias (
		.clk(clk),
		.rst(rst),
		.tree_sum(tree_sum),
		.sum_valid(sum_valid),
		.sum_filter(sum_filter),
		.bias_wr_en(bias_wr_en),
		.bias_addr(wr_addr[FILT_W-1:0]),
		.bias_data(cfg_data),
		.out_ready(out_ready),
		.advance(advance),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// ==== tb/conv_tb_model.svh ====
`ifndef CONV_TB_MODEL_SVH
`define CONV_TB_MODEL_SVH

// relu, then clamp to the 8 bit activation range
function automatic int clamp_act(input int v);
	if (v < 0)
	begin
		return 0;
	end
	if (v > 255)
	begin
		return 255;
	end
	return v;
endfunction

// output of filter f with the window's top-left pixel at (r, c)
function automatic int conv_point(input int f, input int r, input int c);
	int acc;
	acc = bias_mem[f];
	for (int ch = 0; ch < NUM_UNITS; ch++)
	begin
		for (int ky = 0; ky < KERNEL_SIZE; ky++)
		begin
			for (int kx = 0; kx < KERNEL_SIZE; kx++)
			begin
				acc += wt_mem[ch][f * KK + ky * KERNEL_SIZE + kx]
					* frame_mem[(r + ky) * IFM_SIZE + c + kx][ch];
			end
		end
	end
	return clamp_act(acc);
endfunction

// every result of one filter, raster order
task automatic push_filter(input int f);
	for (int r = 0; r < OUT_SIZE; r++)
	begin
		for (int c = 0; c < OUT_SIZE; c++)
		begin
			exp_q.push_back(conv_point(f, r, c));
		end
	end
endtask

`endif

// ==== tb/conv_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;

	import conv_arith_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int IFM_SIZE = 5;
	localparam int KERNEL_SIZE = 3;
	localparam int NUM_FILTERS = 4;
	localparam int NUM_UNITS = 3;
	localparam int KK = KERNEL_SIZE * KERNEL_SIZE;
	localparam int OUT_SIZE = IFM_SIZE - KERNEL_SIZE + 1;
	localparam int UNIT_W = $clog2(NUM_UNITS);
	localparam int WADDR_W = $clog2(NUM_FILTERS * KK);
	localparam int WAIT_LIMIT = 100;
	localparam int DONE_LIMIT = 300;
	localparam logic [31:0] SEED = 32'hc492d3a7;

	logic clk = 1'b0;
	logic rst;
	logic cfg_valid;
	logic cfg_ready;
	cfg_op_t cfg_op;
	logic [UNIT_W-1:0] cfg_unit;
	logic [WADDR_W-1:0] cfg_addr;
	acc_t cfg_data;
	logic start;
	logic in_valid;
	logic in_ready;
	logic [NUM_UNITS*8-1:0] in_pixels;
	logic out_valid;
	logic out_ready = 1'b0;
	out_t out_data;
	logic busy;

	logic [31:0] stim_lfsr = SEED;
	logic [31:0] stall_lfsr = SEED;
	logic stall_bit;
	logic cfg_taken = 1'b0;
	logic pix_taken = 1'b0;
	logic beat_taken = 1'b0;
	out_t exp_head = '0;
	logic exp_empty = 1'b1;
	int exp_q [$];
	int beat_cnt = 0;
	int total_expected = 0;
	int data_errs = 0;
	int proto_errs = 0;
	int timeout_errs = 0;

	// host-side copies of everything written into the DUT
	int wt_mem [NUM_UNITS][NUM_FILTERS*KK];
	int bias_mem [NUM_FILTERS];
	int frame_mem [IFM_SIZE*IFM_SIZE][NUM_UNITS];

	`include "conv_tb_model.svh"

	conv_layer_top dut (
		.clk(clk),
		.rst(rst),
		.cfg_valid(cfg_valid),
		.cfg_ready(cfg_ready),
		.cfg_op(cfg_op),
		.cfg_unit(cfg_unit),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.start(start),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pixels(in_pixels),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.busy(busy)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			stim_lfsr = lfsr_step(stim_lfsr);
			r = {r[30:0], stim_lfsr[0]};
		end
		return r;
	endfunction

	function automatic int rand_signed(input int n);
		int v;
		v = int'(take_bits(n));
		if (v >= (1 << (n - 1)))
		begin
			v -= (1 << n);
		end
		return v;
	endfunction

	task automatic finish_run();
		$display("errors: data %0d, protocol %0d, timeout %0d",
			data_errs, proto_errs, timeout_errs);
		if (data_errs + proto_errs + timeout_errs == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		timeout_errs++;
	endtask

	// handshakes as seen at the clock edge
	always @(posedge clk)
	begin
		cfg_taken <= cfg_valid && cfg_ready;
		pix_taken <= in_valid && in_ready;
		beat_taken <= out_valid && out_ready;
	end

	// ready three cycles in four
	always @(negedge clk)
	begin
		stall_lfsr = lfsr_step(stall_lfsr);
		stall_bit = stall_lfsr[0];
		stall_lfsr = lfsr_step(stall_lfsr);
		out_ready = stall_bit | stall_lfsr[0];
	end

	always @(negedge clk)
	begin
		if (beat_taken)
		begin
			beat_cnt++;
			if (exp_q.size() != 0)
			begin
				void'(exp_q.pop_front());
			end
		end
		exp_empty = (exp_q.size() == 0);
		exp_head = exp_empty ? '0 : out_t'(exp_q[0]);
	end

	a_out_expected: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> !exp_empty)
		else
		begin
			$display("output beat arrived with no result left to expect");
			proto_errs++;
		end

	a_out_data: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready && !exp_empty |-> out_data == exp_head)
		else
		begin
			$display("FAILED out_data: got %h, expected %h", out_data, exp_head);
			data_errs++;
		end

	a_out_stall: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else
		begin
			$display("output beat changed or vanished while stalled");
			proto_errs++;
		end

	a_cfg_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !cfg_ready)
		else
		begin
			$display("configuration port ready while busy");
			proto_errs++;
		end

	a_in_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !in_ready)
		else
		begin
			$display("pixel port ready while not busy");
			proto_errs++;
		end

	task automatic cfg_write(input cfg_op_t op, input int unit, input int addr, input int data);
		int tries;
		cfg_valid = 1'b1;
		cfg_op = op;
		cfg_unit = UNIT_W'(unit);
		cfg_addr = WADDR_W'(addr);
		cfg_data = acc_t'(data);
		tries = 0;
		@(negedge clk);
		while (!cfg_taken && tries < WAIT_LIMIT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!cfg_taken)
		begin
			report_timeout("configuration beat was not accepted");
		end
		cfg_valid = 1'b0;
		cfg_op = op_nop;
	endtask

	task automatic send_frame();
		int tries;
		for (int p = 0; p < IFM_SIZE * IFM_SIZE; p++)
		begin
			// an idle cycle now and then
			if (take_bits(2) == 0)
			begin
				in_valid = 1'b0;
				@(negedge clk);
			end
			for (int ch = 0; ch < NUM_UNITS; ch++)
			begin
				in_pixels[ch*8 +: 8] = 8'(frame_mem[p][ch]);
			end
			in_valid = 1'b1;
			tries = 0;
			@(negedge clk);
			while (!pix_taken && tries < WAIT_LIMIT)
			begin
				tries++;
				@(negedge clk);
			end
			if (!pix_taken)
			begin
				report_timeout("pixel beat was not accepted");
				in_valid = 1'b0;
				return;
			end
		end
		in_valid = 1'b0;
	endtask

	// load, stream one frame per filter, then wait for the drain
	task automatic run_layer(input int wbits, input int pbits, input bit extreme_bias);
		int tries;
		tries = 0;
		while (!cfg_ready && tries < DONE_LIMIT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!cfg_ready)
		begin
			report_timeout("configuration port did not become ready");
			return;
		end
		for (int ch = 0; ch < NUM_UNITS; ch++)
		begin
			for (int a = 0; a < NUM_FILTERS * KK; a++)
			begin
				wt_mem[ch][a] = rand_signed(wbits);
				cfg_write(op_wr_weight, ch, a, wt_mem[ch][a]);
				if (timeout_errs != 0)
				begin
					return;
				end
			end
		end
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			if (extreme_bias && f == 0)
				bias_mem[f] = -(1 << 20);
			else if (extreme_bias && f == 1)
				bias_mem[f] = (1 << 20) - 1;
			else
				bias_mem[f] = rand_signed(extreme_bias ? 9 : 16);
			cfg_write(op_wr_bias, 0, f, bias_mem[f]);
			if (timeout_errs != 0)
			begin
				return;
			end
		end
		// the same frame is re-streamed for every filter
		for (int p = 0; p < IFM_SIZE * IFM_SIZE; p++)
		begin
			for (int ch = 0; ch < NUM_UNITS; ch++)
			begin
				frame_mem[p][ch] = rand_signed(pbits);
			end
		end
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			push_filter(f);
		end
		total_expected += NUM_FILTERS * OUT_SIZE * OUT_SIZE;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			send_frame();
			if (timeout_errs != 0)
			begin
				return;
			end
		end
		tries = 0;
		while (busy && tries < DONE_LIMIT)
		begin
			tries++;
			@(negedge clk);
		end
		if (busy)
		begin
			report_timeout("busy did not fall after the last frame");
			return;
		end
		@(negedge clk);
		a_beat_count: assert (beat_cnt == total_expected && exp_q.size() == 0)
			else
			begin
				$display("FAILED beat_cnt: got %h, expected %h", beat_cnt, total_expected);
				data_errs++;
			end
	endtask

	initial
	begin
		rst = 1'b1;
		cfg_valid = 1'b0;
		cfg_op = op_nop;
		cfg_unit = '0;
		cfg_addr = '0;
		cfg_data = '0;
		start = 1'b0;
		in_valid = 1'b0;
		in_pixels = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// small values keep many results inside the 8 bit range
		run_layer(4, 4, 1'b1);
		// every weight reloaded, full range data
		if (timeout_errs == 0)
		begin
			run_layer(8, 8, 1'b0);
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tb
design/conv_arith_pkg.sv
design/conv_ctrl_pkg.sv
design/conv_window_unit.sv
design/channel_sum_tree.sv
design/bias_relu_stage.sv
design/conv_layer_ctrl.sv
design/conv_layer_top.sv
tb/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench and RTL with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_layer_tb -f files.f -o conv_layer_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/conv_layer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
